// File: src/pce_cfg.svh
// Cache geometry for the engine. The line is fixed at 16 bytes (two dwords)
// and the set and way counts must be powers of two
`ifndef PCE_CFG_SVH
`define PCE_CFG_SVH

`define PCE_PADDR_W 32
`define PCE_SETS    64
`define PCE_WAYS    4
`define PCE_RET_ELS 4

`define PCE_DWORD_W  64
`define PCE_LINE_W   128
`define PCE_OFFSET_W 4
`define PCE_INDEX_W  $clog2(`PCE_SETS)
`define PCE_WAY_W    $clog2(`PCE_WAYS)
`define PCE_TAG_W    (`PCE_PADDR_W - `PCE_INDEX_W - `PCE_OFFSET_W)

`endif

// File: src/pce_pkg.sv
// Encodings shared by the engine and the cache-side checker
`default_nettype none
`include "pce_cfg.svh"

package pce_pkg;

  typedef enum logic [1:0] {e_miss_load, e_uc_load, e_uc_store} pce_msg_e;

  typedef enum logic [1:0] {e_size_1b, e_size_2b, e_size_4b, e_size_8b} pce_size_e;

  typedef enum logic [1:0] {e_load_req, e_store_req} l15_rqtype_e;

  typedef enum logic [1:0] {e_load_ret, e_st_ack, e_evict_req} l15_rtntype_e;

  typedef enum logic {e_data_write, e_data_uncached} data_op_e;

  typedef enum logic [1:0] {e_tag_clear, e_tag_set_tag, e_tag_set_state} tag_op_e;

  typedef enum logic [1:0] {e_coh_i, e_coh_s, e_coh_m} coh_state_e;

  typedef enum logic [1:0] {e_wait_none, e_wait_st_ack, e_wait_uc_data, e_wait_fill} wait_e;

  // One L1.5 return as it sits in the return FIFO
  typedef struct packed {
    l15_rtntype_e            rtntype;
    logic                    noncacheable;
    logic [`PCE_DWORD_W-1:0] data_1;
    logic [`PCE_DWORD_W-1:0] data_0;
    logic                    inval;
    logic [`PCE_INDEX_W-1:0] inval_index;
    logic [`PCE_WAY_W-1:0]   inval_way;
  } pce_ret_s;

  // L1.5 is big endian, the cache little endian
  function automatic logic [`PCE_DWORD_W-1:0] bswap64(input logic [`PCE_DWORD_W-1:0] d);
    logic [`PCE_DWORD_W-1:0] r;
    for (int i = 0; i < 8; i++)
      r[8*i +: 8] = d[8*(7-i) +: 8];
    return r;
  endfunction

endpackage

`default_nettype wire

// File: src/pce_ctrl.sv
// Takes one request at a time and holds it until completion
// No request is taken before the tag clear sweep has finished
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  input  pce_pkg::pce_msg_e       req_msg_i,
  input  logic [`PCE_PADDR_W-1:0] req_addr_i,
  input  pce_pkg::pce_size_e      req_size_i,
  input  logic [`PCE_DWORD_W-1:0] req_data_i,
  input  logic [`PCE_WAY_W-1:0]   req_way_i,
  output logic                    req_yumi_o,
  output logic                    req_busy_o,
  output logic                    req_complete_o,
  input  logic                    l15_req_ready_i,
  output logic                    l15_req_v_o,
  input  logic                    init_done_i,
  input  logic                    ret_done_i,
  output pce_pkg::pce_msg_e       held_msg_o,
  output logic [`PCE_PADDR_W-1:0] held_addr_o,
  output pce_pkg::pce_size_e      held_size_o,
  output logic [`PCE_DWORD_W-1:0] held_data_o,
  output logic [`PCE_WAY_W-1:0]   held_way_o,
  output pce_pkg::wait_e          wait_o
);
  import pce_pkg::*;

  typedef enum logic [1:0] {st_idle, st_send, st_wait, st_done} state_e;

  state_e state_r;
  state_e state_n;

  assign req_yumi_o     = req_v_i & init_done_i & (state_r == st_idle);
  assign req_busy_o     = ~init_done_i | (state_r != st_idle);
  assign req_complete_o = (state_r == st_done);
  assign l15_req_v_o    = (state_r == st_send);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      st_idle:
        if (req_yumi_o)
          state_n = st_send;
      st_send:
        if (l15_req_ready_i)
          state_n = st_wait;
      st_wait:
        if (ret_done_i)
          state_n = st_done;
      default:
        state_n = st_idle;
    endcase
  end

  // Tells the writer which return closes the request
  always_comb
  begin
    wait_o = e_wait_none;
    if (state_r == st_wait)
    begin
      case (held_msg_o)
        e_uc_store: wait_o = e_wait_st_ack;
        e_uc_load:  wait_o = e_wait_uc_data;
        default:    wait_o = e_wait_fill;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= st_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (req_yumi_o)
    begin
      held_msg_o  <= req_msg_i;
      held_addr_o <= req_addr_i;
      held_size_o <= req_size_i;
      held_data_o <= req_data_i;
      held_way_o  <= req_way_i;
    end
  end

endmodule

`default_nettype wire

// File: src/pce_l15_encode.sv
// Purely combinational; outputs follow the held request
// Misses always fetch a whole 16-byte line
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_l15_encode (
  input  pce_pkg::pce_msg_e       held_msg_i,
  input  logic [`PCE_PADDR_W-1:0] held_addr_i,
  input  pce_pkg::pce_size_e      held_size_i,
  input  logic [`PCE_DWORD_W-1:0] held_data_i,
  input  logic [`PCE_WAY_W-1:0]   held_way_i,
  output pce_pkg::l15_rqtype_e    l15_req_type_o,
  output logic                    l15_req_nc_o,
  output logic [`PCE_PADDR_W-1:0] l15_req_addr_o,
  output logic [2:0]              l15_req_size_o,
  output logic [`PCE_DWORD_W-1:0] l15_req_data_o,
  output logic [`PCE_WAY_W-1:0]   l15_req_way_o
);
  import pce_pkg::*;

  logic                    is_miss;
  logic [`PCE_DWORD_W-1:0] swapped;

  assign is_miss        = (held_msg_i == e_miss_load);
  assign swapped        = bswap64(held_data_i);
  assign l15_req_type_o = (held_msg_i == e_uc_store) ? e_store_req : e_load_req;
  assign l15_req_nc_o   = ~is_miss;
  assign l15_req_way_o  = held_way_i;

  // L1.5 size code 3'b111 is a full line
  assign l15_req_size_o = is_miss ? 3'b111 : {1'b0, held_size_i};
  assign l15_req_addr_o = is_miss
                          ? {held_addr_i[`PCE_PADDR_W-1:`PCE_OFFSET_W], {`PCE_OFFSET_W{1'b0}}}
                          : held_addr_i;

  // Swapped value has the lowest byte on top, so narrow stores take the top bytes
  always_comb
  begin
    case (held_size_i)
      e_size_1b: l15_req_data_o = {8{swapped[63:56]}};
      e_size_2b: l15_req_data_o = {4{swapped[63:48]}};
      e_size_4b: l15_req_data_o = {2{swapped[63:32]}};
      default:   l15_req_data_o = swapped;
    endcase
  end

endmodule

`default_nettype wire

// File: src/pce_ret_fifo.sv
// Return buffer; yumi_i is only honoured while v_o is high
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_ret_fifo #(
  parameter int els_p = 4
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              v_i,
  input  pce_pkg::pce_ret_s data_i,
  output logic              ready_o,
  output logic              v_o,
  output pce_pkg::pce_ret_s data_o,
  input  logic              yumi_i
);
  import pce_pkg::*;

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  pce_ret_s            mem_r [els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                enq;
  logic                deq;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
    return (p == ptr_w_lp'(els_p - 1)) ? '0 : p + ptr_w_lp'(1);
  endfunction

  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (deq)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      count_r <= count_r + cnt_w_lp'(enq) - cnt_w_lp'(deq);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

// File: src/pce_mem_writer.sv
// Returns at the FIFO head are ignored until the clear sweep is over
// A return that matches neither an evict nor the awaited kind stays at the head
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_mem_writer (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    ret_v_i,
  input  pce_pkg::pce_ret_s       ret_i,
  output logic                    ret_yumi_o,
  input  pce_pkg::wait_e          wait_i,
  input  logic [`PCE_PADDR_W-1:0] held_addr_i,
  input  logic [`PCE_WAY_W-1:0]   held_way_i,
  output logic                    ret_done_o,
  output logic                    init_done_o,
  output logic                    data_mem_v_o,
  output pce_pkg::data_op_e       data_mem_op_o,
  output logic [`PCE_INDEX_W-1:0] data_mem_index_o,
  output logic [`PCE_WAY_W-1:0]   data_mem_way_o,
  output logic [`PCE_LINE_W-1:0]  data_mem_data_o,
  input  logic                    data_mem_yumi_i,
  output logic                    tag_mem_v_o,
  output pce_pkg::tag_op_e        tag_mem_op_o,
  output logic [`PCE_INDEX_W-1:0] tag_mem_index_o,
  output logic [`PCE_WAY_W-1:0]   tag_mem_way_o,
  output logic [`PCE_TAG_W-1:0]   tag_mem_tag_o,
  output pce_pkg::coh_state_e     tag_mem_state_o,
  input  logic                    tag_mem_yumi_i
);
  import pce_pkg::*;

  localparam int index_w_lp = `PCE_INDEX_W;

  logic [`PCE_INDEX_W-1:0] clr_idx_r;
  logic                    init_done_r;
  logic                    data_taken_r;
  logic                    tag_taken_r;
  logic                    head_v;
  logic                    is_evict;
  logic                    is_st_ack;
  logic                    is_uc_data;
  logic                    is_fill;
  logic                    data_taken;
  logic                    tag_taken;
  logic [`PCE_INDEX_W-1:0] held_index;
  logic [`PCE_DWORD_W-1:0] uc_dword;

  assign head_v     = init_done_r & ret_v_i;
  assign is_evict   = head_v & (ret_i.rtntype == e_evict_req);
  assign is_st_ack  = head_v & (ret_i.rtntype == e_st_ack) & ret_i.noncacheable
                      & (wait_i == e_wait_st_ack);
  assign is_uc_data = head_v & (ret_i.rtntype == e_load_ret) & ret_i.noncacheable
                      & (wait_i == e_wait_uc_data);
  assign is_fill    = head_v & (ret_i.rtntype == e_load_ret) & ~ret_i.noncacheable
                      & (wait_i == e_wait_fill);

  // A fill retires once both packets have gone, in either order
  assign data_taken  = data_taken_r | data_mem_yumi_i;
  assign tag_taken   = tag_taken_r | tag_mem_yumi_i;
  assign init_done_o = init_done_r;
  assign held_index  = held_addr_i[`PCE_OFFSET_W +: `PCE_INDEX_W];
  assign uc_dword    = held_addr_i[3] ? ret_i.data_1 : ret_i.data_0;

  always_comb
  begin
    data_mem_v_o     = is_uc_data | (is_fill & ~data_taken_r);
    data_mem_op_o    = is_uc_data ? e_data_uncached : e_data_write;
    data_mem_index_o = held_index;
    data_mem_way_o   = held_way_i;
    data_mem_data_o  = is_uc_data ? {2{bswap64(uc_dword)}}
                                  : {bswap64(ret_i.data_1), bswap64(ret_i.data_0)};
    tag_mem_v_o      = 1'b0;
    tag_mem_op_o     = e_tag_set_tag;
    tag_mem_index_o  = held_index;
    tag_mem_way_o    = held_way_i;
    tag_mem_tag_o    = held_addr_i[`PCE_PADDR_W-1 -: `PCE_TAG_W];
    tag_mem_state_o  = e_coh_m;
    ret_yumi_o       = 1'b0;
    ret_done_o       = 1'b0;

    if (~init_done_r)
    begin
      tag_mem_v_o     = 1'b1;
      tag_mem_op_o    = e_tag_clear;
      tag_mem_index_o = clr_idx_r;
    end
    else if (is_evict)
    begin
      // Evicts without the inval flag carry nothing for this cache
      tag_mem_v_o     = ret_i.inval;
      tag_mem_op_o    = e_tag_set_state;
      tag_mem_index_o = ret_i.inval_index;
      tag_mem_way_o   = ret_i.inval_way;
      tag_mem_state_o = e_coh_i;
      ret_yumi_o      = ~ret_i.inval | tag_mem_yumi_i;
    end
    else if (is_st_ack)
    begin
      ret_yumi_o = 1'b1;
      ret_done_o = 1'b1;
    end
    else if (is_uc_data)
    begin
      ret_yumi_o = data_mem_yumi_i;
      ret_done_o = data_mem_yumi_i;
    end
    else if (is_fill)
    begin
      tag_mem_v_o = ~tag_taken_r;
      ret_yumi_o  = data_taken & tag_taken;
      ret_done_o  = data_taken & tag_taken;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      clr_idx_r    <= '0;
      init_done_r  <= 1'b0;
      data_taken_r <= 1'b0;
      tag_taken_r  <= 1'b0;
    end
    else
    begin
      if (~init_done_r & tag_mem_yumi_i)
      begin
        clr_idx_r <= clr_idx_r + index_w_lp'(1);
        if (clr_idx_r == index_w_lp'(`PCE_SETS - 1))
          init_done_r <= 1'b1;
      end
      if (ret_done_o)
      begin
        data_taken_r <= 1'b0;
        tag_taken_r  <= 1'b0;
      end
      else if (is_fill)
      begin
        data_taken_r <= data_taken;
        tag_taken_r  <= tag_taken;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pce_top.sv
// Data cache engine between the L1 data cache and a big-endian L1.5
// Memory packets hold valid and fields until the matching yumi
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_v_i,
  input  pce_pkg::pce_msg_e         req_msg_i,
  input  logic [`PCE_PADDR_W-1:0]   req_addr_i,
  input  pce_pkg::pce_size_e        req_size_i,
  input  logic [`PCE_DWORD_W-1:0]   req_data_i,
  input  logic [`PCE_WAY_W-1:0]     req_way_i,
  output logic                      req_yumi_o,
  output logic                      req_busy_o,
  output logic                      req_complete_o,
  output logic                      l15_req_v_o,
  output pce_pkg::l15_rqtype_e      l15_req_type_o,
  output logic                      l15_req_nc_o,
  output logic [`PCE_PADDR_W-1:0]   l15_req_addr_o,
  output logic [2:0]                l15_req_size_o,
  output logic [`PCE_DWORD_W-1:0]   l15_req_data_o,
  output logic [`PCE_WAY_W-1:0]     l15_req_way_o,
  input  logic                      l15_req_ready_i,
  input  logic                      l15_ret_v_i,
  input  pce_pkg::l15_rtntype_e     l15_ret_rtntype_i,
  input  logic                      l15_ret_nc_i,
  input  logic [`PCE_DWORD_W-1:0]   l15_ret_data_0_i,
  input  logic [`PCE_DWORD_W-1:0]   l15_ret_data_1_i,
  input  logic                      l15_ret_inval_i,
  input  logic [`PCE_INDEX_W-1:0]   l15_ret_inval_index_i,
  input  logic [`PCE_WAY_W-1:0]     l15_ret_inval_way_i,
  output logic                      l15_ret_ready_o,
  output logic                      data_mem_v_o,
  output pce_pkg::data_op_e         data_mem_op_o,
  output logic [`PCE_INDEX_W-1:0]   data_mem_index_o,
  output logic [`PCE_WAY_W-1:0]     data_mem_way_o,
  output logic [`PCE_LINE_W-1:0]    data_mem_data_o,
  input  logic                      data_mem_yumi_i,
  output logic                      tag_mem_v_o,
  output pce_pkg::tag_op_e          tag_mem_op_o,
  output logic [`PCE_INDEX_W-1:0]   tag_mem_index_o,
  output logic [`PCE_WAY_W-1:0]     tag_mem_way_o,
  output logic [`PCE_TAG_W-1:0]     tag_mem_tag_o,
  output pce_pkg::coh_state_e       tag_mem_state_o,
  input  logic                      tag_mem_yumi_i
);
  import pce_pkg::*;

  pce_msg_e                held_msg;
  logic [`PCE_PADDR_W-1:0] held_addr;
  pce_size_e               held_size;
  logic [`PCE_DWORD_W-1:0] held_data;
  logic [`PCE_WAY_W-1:0]   held_way;
  wait_e                   wait_kind;
  logic                    init_done;
  logic                    ret_done;
  pce_ret_s                ret_in;
  pce_ret_s                ret_head;
  logic                    ret_v;
  logic                    ret_yumi;

  assign ret_in = '{rtntype: l15_ret_rtntype_i, noncacheable: l15_ret_nc_i,
                    data_1: l15_ret_data_1_i, data_0: l15_ret_data_0_i,
                    inval: l15_ret_inval_i, inval_index: l15_ret_inval_index_i,
                    inval_way: l15_ret_inval_way_i};

  pce_ctrl ctrl0 (
    .clk_i, .reset_i,
    .req_v_i, .req_msg_i, .req_addr_i, .req_size_i, .req_data_i, .req_way_i,
    .req_yumi_o, .req_busy_o, .req_complete_o,
    .l15_req_ready_i, .l15_req_v_o,
    .init_done_i(init_done), .ret_done_i(ret_done),
    .held_msg_o(held_msg), .held_addr_o(held_addr), .held_size_o(held_size),
    .held_data_o(held_data), .held_way_o(held_way),
    .wait_o(wait_kind)
  );

  pce_l15_encode encode0 (
    .held_msg_i(held_msg), .held_addr_i(held_addr), .held_size_i(held_size),
    .held_data_i(held_data), .held_way_i(held_way),
    .l15_req_type_o, .l15_req_nc_o, .l15_req_addr_o,
    .l15_req_size_o, .l15_req_data_o, .l15_req_way_o
  );

  pce_ret_fifo #(.els_p(`PCE_RET_ELS)) ret_fifo0 (
    .clk_i, .reset_i,
    .v_i(l15_ret_v_i), .data_i(ret_in), .ready_o(l15_ret_ready_o),
    .v_o(ret_v), .data_o(ret_head), .yumi_i(ret_yumi)
  );

  pce_mem_writer writer0 (
    .clk_i, .reset_i,
    .ret_v_i(ret_v), .ret_i(ret_head), .ret_yumi_o(ret_yumi),
    .wait_i(wait_kind), .held_addr_i(held_addr), .held_way_i(held_way),
    .ret_done_o(ret_done), .init_done_o(init_done),
    .data_mem_v_o, .data_mem_op_o, .data_mem_index_o, .data_mem_way_o,
    .data_mem_data_o, .data_mem_yumi_i,
    .tag_mem_v_o, .tag_mem_op_o, .tag_mem_index_o, .tag_mem_way_o,
    .tag_mem_tag_o, .tag_mem_state_o, .tag_mem_yumi_i
  );

endmodule

`default_nettype wire

// File: dv/pce_checker.sv
// Watches the engine ports and compares every transfer with values worked out
// from the vector in flight; counts start at test_start_i
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module pce_checker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    test_start_i,
  input  logic                    test_end_i,
  input  logic [3:0]              cur_kind_i,
  input  logic [31:0]             cur_addr_i,
  input  logic [1:0]              cur_size_i,
  input  logic [1:0]              cur_way_i,
  input  logic [63:0]             cur_sdata_i,
  input  logic [63:0]             cur_d1_i,
  input  logic [63:0]             cur_d0_i,
  input  logic                    cur_evict_i,
  input  logic [5:0]              cur_eidx_i,
  input  logic [1:0]              cur_eway_i,
  input  logic                    req_v_i,
  input  logic                    req_yumi_o,
  input  logic                    req_busy_o,
  input  logic                    req_complete_o,
  input  logic                    l15_req_v_o,
  input  logic                    l15_req_ready_i,
  input  pce_pkg::l15_rqtype_e    l15_req_type_o,
  input  logic                    l15_req_nc_o,
  input  logic [31:0]             l15_req_addr_o,
  input  logic [2:0]              l15_req_size_o,
  input  logic [63:0]             l15_req_data_o,
  input  logic [1:0]              l15_req_way_o,
  input  logic                    l15_ret_v_i,
  input  logic                    l15_ret_ready_o,
  input  logic                    data_mem_v_o,
  input  logic                    data_mem_yumi_i,
  input  pce_pkg::data_op_e       data_mem_op_o,
  input  logic [5:0]              data_mem_index_o,
  input  logic [1:0]              data_mem_way_o,
  input  logic [127:0]            data_mem_data_o,
  input  logic                    tag_mem_v_o,
  input  logic                    tag_mem_yumi_i,
  input  pce_pkg::tag_op_e        tag_mem_op_o,
  input  logic [5:0]              tag_mem_index_o,
  input  logic [1:0]              tag_mem_way_o,
  input  logic [21:0]             tag_mem_tag_o,
  input  pce_pkg::coh_state_e     tag_mem_state_o,
  output int                      tests_o,
  output int                      fails_o
);
  import pce_pkg::*;

  int   sweep_cnt;
  logic sweep_done;
  int   n_req;
  int   n_acc;
  int   n_data;
  int   n_tag;
  int   n_inv;
  int   n_cmp;
  int   test_errs;

  // L1.5 lanes are big endian
  function automatic logic [63:0] reverse_bytes(input logic [63:0] d);
    logic [63:0] r;
    for (int i = 0; i < 8; i++)
      r[8*(7-i) +: 8] = d[8*i +: 8];
    return r;
  endfunction

  // Low n bytes in big-endian order, repeated over the dword
  function automatic logic [63:0] store_lanes(input logic [63:0] d, input logic [1:0] size);
    logic [63:0] r;
    int          n;
    n = 1 << size;
    for (int i = 0; i < 8; i++)
      r[8*(7-i) +: 8] = d[8*(i % n) +: 8];
    return r;
  endfunction

  task automatic expect_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  initial
  begin
    tests_o    = 0;
    fails_o    = 0;
    sweep_cnt  = 0;
    sweep_done = 1'b0;
    test_errs  = 0;
  end

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sweep_cnt  = 0;
      sweep_done = 1'b0;
    end
    else
    begin
      if (!sweep_done && !req_busy_o)
      begin
        sweep_done = 1'b1;
        tests_o++;
        expect_eq("tag clears before busy fell", 128'(sweep_cnt), 128'(64));
        if (test_errs == 0)
          $display("test sweep: ok");
        else
        begin
          fails_o++;
          $display("test sweep: mismatch, %0d errors", test_errs);
        end
        test_errs = 0;
      end

      if (test_start_i)
      begin
        n_req     = 0;
        n_acc     = 0;
        n_data    = 0;
        n_tag     = 0;
        n_inv     = 0;
        n_cmp     = 0;
      end

      // Requests are taken only while the engine is free
      if (req_busy_o)
        expect_eq("yumi while busy", 128'(req_yumi_o), 128'(0));
      else
        expect_eq("yumi while free", 128'(req_yumi_o), 128'(req_v_i));
      if (req_v_i && req_yumi_o)
        n_acc++;

      // The model never has more than two returns queued
      if (l15_ret_v_i)
        expect_eq("l15 return ready", 128'(l15_ret_ready_o), 128'(1));

      if (l15_req_v_o && l15_req_ready_i)
      begin
        n_req++;
        expect_eq("l15 type", 128'(l15_req_type_o),
                  128'((cur_kind_i == 4'd2) ? e_store_req : e_load_req));
        expect_eq("l15 nc", 128'(l15_req_nc_o), 128'(cur_kind_i != 4'd0));
        expect_eq("l15 addr", 128'(l15_req_addr_o),
                  128'((cur_kind_i == 4'd0) ? {cur_addr_i[31:4], 4'h0} : cur_addr_i));
        expect_eq("l15 size", 128'(l15_req_size_o),
                  128'((cur_kind_i == 4'd0) ? 3'b111 : {1'b0, cur_size_i}));
        expect_eq("l15 way", 128'(l15_req_way_o), 128'(cur_way_i));
        if (cur_kind_i == 4'd2)
          expect_eq("l15 store data", 128'(l15_req_data_o),
                    128'(store_lanes(cur_sdata_i, cur_size_i)));
      end

      if (data_mem_v_o && data_mem_yumi_i)
      begin
        n_data++;
        expect_eq("data index", 128'(data_mem_index_o), 128'(cur_addr_i[9:4]));
        expect_eq("data way", 128'(data_mem_way_o), 128'(cur_way_i));
        if (cur_kind_i == 4'd1)
        begin
          expect_eq("data op", 128'(data_mem_op_o), 128'(e_data_uncached));
          expect_eq("uncached data", data_mem_data_o,
                    {2{reverse_bytes(cur_addr_i[3] ? cur_d1_i : cur_d0_i)}});
        end
        else
        begin
          expect_eq("data op", 128'(data_mem_op_o), 128'(e_data_write));
          expect_eq("line data", data_mem_data_o,
                    {reverse_bytes(cur_d1_i), reverse_bytes(cur_d0_i)});
        end
      end

      if (tag_mem_v_o && tag_mem_yumi_i)
      begin
        if (!sweep_done)
        begin
          expect_eq("clear op", 128'(tag_mem_op_o), 128'(e_tag_clear));
          expect_eq("clear index", 128'(tag_mem_index_o), 128'(sweep_cnt));
          sweep_cnt++;
        end
        else if (tag_mem_op_o == e_tag_set_state)
        begin
          n_inv++;
          expect_eq("inval index", 128'(tag_mem_index_o), 128'(cur_eidx_i));
          expect_eq("inval way", 128'(tag_mem_way_o), 128'(cur_eway_i));
          expect_eq("inval state", 128'(tag_mem_state_o), 128'(e_coh_i));
        end
        else
        begin
          n_tag++;
          expect_eq("tag op", 128'(tag_mem_op_o), 128'(e_tag_set_tag));
          expect_eq("tag index", 128'(tag_mem_index_o), 128'(cur_addr_i[9:4]));
          expect_eq("tag way", 128'(tag_mem_way_o), 128'(cur_way_i));
          expect_eq("tag value", 128'(tag_mem_tag_o), 128'(cur_addr_i[31:10]));
          expect_eq("tag state", 128'(tag_mem_state_o), 128'(e_coh_m));
        end
      end

      if (req_complete_o)
        n_cmp++;

      if (test_end_i)
      begin
        expect_eq("accept count", 128'(n_acc), 128'(cur_kind_i != 4'd3));
        expect_eq("l15 request count", 128'(n_req), 128'(cur_kind_i != 4'd3));
        expect_eq("data packet count", 128'(n_data), 128'(cur_kind_i < 4'd2));
        expect_eq("tag fill count", 128'(n_tag), 128'(cur_kind_i == 4'd0));
        expect_eq("inval count", 128'(n_inv), 128'(cur_kind_i == 4'd3 || cur_evict_i));
        expect_eq("complete count", 128'(n_cmp), 128'(cur_kind_i != 4'd3));
        tests_o++;
        if (test_errs == 0)
          $display("test %0d kind %0d: ok", tests_o - 1, cur_kind_i);
        else
        begin
          fails_o++;
          $display("test %0d kind %0d: mismatch, %0d errors", tests_o - 1, cur_kind_i,
                   test_errs);
        end
        test_errs = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_pce.sv
// Vectors come from dv/pce_testdata.hex, run from the project root
// The L1.5 model answers each request in order; evicts go out ahead of the reply
`timescale 1ns/1ps
`default_nettype none
`include "pce_cfg.svh"

module tb_pce;
  import pce_pkg::*;

  localparam int n_vec_lp = 10;
  localparam int limit_lp = 100 + 60 * n_vec_lp;

  logic clk_i = 1'b0;
  logic reset_i;
  logic req_v_i;
  pce_msg_e req_msg_i;
  logic [31:0] req_addr_i;
  pce_size_e req_size_i;
  logic [63:0] req_data_i;
  logic [1:0] req_way_i;
  logic req_yumi_o, req_busy_o, req_complete_o;
  logic l15_req_v_o, l15_req_nc_o;
  l15_rqtype_e l15_req_type_o;
  logic [31:0] l15_req_addr_o;
  logic [2:0] l15_req_size_o;
  logic [63:0] l15_req_data_o;
  logic [1:0] l15_req_way_o;
  logic l15_req_ready_i = 1'b0;
  logic l15_ret_v_i;
  l15_rtntype_e l15_ret_rtntype_i;
  logic l15_ret_nc_i, l15_ret_inval_i, l15_ret_ready_o;
  logic [63:0] l15_ret_data_0_i, l15_ret_data_1_i;
  logic [5:0] l15_ret_inval_index_i;
  logic [1:0] l15_ret_inval_way_i;
  logic data_mem_v_o, data_mem_yumi_i, tag_mem_v_o, tag_mem_yumi_i;
  data_op_e data_mem_op_o;
  logic [5:0] data_mem_index_o, tag_mem_index_o;
  logic [1:0] data_mem_way_o, tag_mem_way_o;
  logic [127:0] data_mem_data_o;
  tag_op_e tag_mem_op_o;
  logic [21:0] tag_mem_tag_o;
  coh_state_e tag_mem_state_o;

  logic [251:0] vecs [n_vec_lp];
  logic [31:0]  rng = 32'he1705ae6;
  logic         data_go = 1'b0;
  logic         tag_go = 1'b0;
  logic         evict_seen = 1'b0;
  logic         test_start, test_end;
  logic [251:0] cur;
  int           cycles = 0;
  int           tests, fails;

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random stalls on the L1.5 ready and both memory yumis
  always @(posedge clk_i)
  begin
    rng = xorshift32(rng);
    l15_req_ready_i <= |rng[1:0];
    data_go         <= |rng[3:2];
    tag_go          <= |rng[5:4];
  end

  assign data_mem_yumi_i = data_mem_v_o & data_go;
  assign tag_mem_yumi_i  = tag_mem_v_o & tag_go;

  always @(posedge clk_i)
  begin
    if (test_start)
      evict_seen <= 1'b0;
    else if (tag_mem_v_o && tag_mem_yumi_i && tag_mem_op_o == e_tag_set_state)
      evict_seen <= 1'b1;
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= limit_lp)
    begin
      $display("timeout: run did not finish within %0d cycles", limit_lp);
      $display("TESTS FAILED");
      $finish;
    end
  end

  pce_top dut0 (.*);

  pce_checker chk0 (
    .clk_i, .reset_i, .test_start_i(test_start), .test_end_i(test_end),
    .cur_kind_i(cur[251:248]), .cur_addr_i(cur[247:216]), .cur_size_i(cur[213:212]),
    .cur_way_i(cur[209:208]), .cur_sdata_i(cur[207:144]), .cur_d1_i(cur[143:80]),
    .cur_d0_i(cur[79:16]), .cur_evict_i(cur[12]), .cur_eidx_i(cur[9:4]),
    .cur_eway_i(cur[1:0]),
    .req_v_i, .req_yumi_o,
    .req_busy_o, .req_complete_o, .l15_req_v_o, .l15_req_ready_i, .l15_req_type_o,
    .l15_req_nc_o, .l15_req_addr_o, .l15_req_size_o, .l15_req_data_o, .l15_req_way_o,
    .l15_ret_v_i, .l15_ret_ready_o,
    .data_mem_v_o, .data_mem_yumi_i, .data_mem_op_o, .data_mem_index_o,
    .data_mem_way_o, .data_mem_data_o,
    .tag_mem_v_o, .tag_mem_yumi_i, .tag_mem_op_o, .tag_mem_index_o, .tag_mem_way_o,
    .tag_mem_tag_o, .tag_mem_state_o,
    .tests_o(tests), .fails_o(fails)
  );

  task automatic send_return(input l15_rtntype_e kind, input logic nc, input logic [63:0] d1,
                             input logic [63:0] d0, input logic inval,
                             input logic [5:0] idx, input logic [1:0] way);
    l15_ret_v_i           <= 1'b1;
    l15_ret_rtntype_i     <= kind;
    l15_ret_nc_i          <= nc;
    l15_ret_data_1_i      <= d1;
    l15_ret_data_0_i      <= d0;
    l15_ret_inval_i       <= inval;
    l15_ret_inval_index_i <= idx;
    l15_ret_inval_way_i   <= way;
    do
      @(posedge clk_i);
    while (!l15_ret_ready_o);
    l15_ret_v_i <= 1'b0;
  endtask

  task automatic run_vector(input logic [251:0] v);
    logic [3:0] kind;
    kind = v[251:248];
    @(posedge clk_i);
    cur        <= v;
    test_start <= 1'b1;
    req_v_i    <= (kind != 4'd3);
    req_msg_i  <= pce_msg_e'(v[249:248]);
    req_addr_i <= v[247:216];
    req_size_i <= pce_size_e'(v[213:212]);
    req_way_i  <= v[209:208];
    req_data_i <= v[207:144];
    @(posedge clk_i);
    test_start <= 1'b0;
    if (kind == 4'd3)
      send_return(e_evict_req, 1'b0, '0, '0, 1'b1, v[9:4], v[1:0]);
    else
    begin
      while (!req_yumi_o)
        @(posedge clk_i);
      req_v_i <= 1'b0;
      do
        @(posedge clk_i);
      while (!(l15_req_v_o && l15_req_ready_i));
      if (v[12])
        send_return(e_evict_req, 1'b0, '0, '0, 1'b1, v[9:4], v[1:0]);
      if (kind == 4'd2)
        send_return(e_st_ack, 1'b1, '0, '0, 1'b0, '0, '0);
      else
        send_return(e_load_ret, kind == 4'd1, v[143:80], v[79:16], 1'b0, '0, '0);
      while (!req_complete_o)
        @(posedge clk_i);
    end
    if (kind == 4'd3 || v[12])
      while (!evict_seen)
        @(posedge clk_i);
    // Room for a stray second completion to show up in the counts
    repeat (3) @(posedge clk_i);
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  initial
  begin
    $readmemh("dv/pce_testdata.hex", vecs);
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_msg_i = e_miss_load;
    req_addr_i = '0;
    req_size_i = e_size_1b;
    req_data_i = '0;
    req_way_i = '0;
    l15_ret_v_i = 1'b0;
    l15_ret_rtntype_i = e_load_ret;
    l15_ret_nc_i = 1'b0;
    l15_ret_data_0_i = '0;
    l15_ret_data_1_i = '0;
    l15_ret_inval_i = 1'b0;
    l15_ret_inval_index_i = '0;
    l15_ret_inval_way_i = '0;
    test_start = 1'b0;
    test_end = 1'b0;
    cur = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    do
      @(posedge clk_i);
    while (req_busy_o);
    for (int i = 0; i < n_vec_lp; i++)
      run_vector(vecs[i]);
    repeat (2) @(posedge clk_i);
    $display("tests run %0d, passed %0d, failed %0d", tests, tests - fails, fails);
    if (fails == 0 && tests == n_vec_lp + 1)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/pce_pkg.sv
src/pce_ctrl.sv
src/pce_l15_encode.sv
src/pce_ret_fifo.sv
src/pce_mem_writer.sv
src/pce_top.sv
dv/pce_checker.sv
dv/tb_pce.sv

// File: Makefile
# Verilator build and run of the cache engine testbench

VERILATOR ?= verilator
TOP       ?= tb_pce
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/pce_testdata.hex
// kind(0 miss,1 uc load,2 uc store,3 evict only)_addr_size_way_storedata_retdword1_retdword0
// _evict(1 = send an evict)_evictindex_evictway
2_80001008_0_1_00000000000000a5_0000000000000000_0000000000000000_0_00_0
2_80001012_1_2_000000000000b1c2_0000000000000000_0000000000000000_0_00_0
2_80001014_2_0_00000000a1b2c3d4_0000000000000000_0000000000000000_0_00_0
2_80001018_3_3_0123456789abcdef_0000000000000000_0000000000000000_0_00_0
1_90000008_3_0_0000000000000000_1122334455667788_99aabbccddeeff00_0_00_0
1_90000010_2_1_0000000000000000_0f1e2d3c4b5a6978_8796a5b4c3d2e1f0_0_00_0
0_12345678_0_2_0000000000000000_fedcba9876543210_0011223344556677_0_00_0
0_abcdef40_0_3_0000000000000000_a0a1a2a3a4a5a6a7_b0b1b2b3b4b5b6b7_1_0f_2
3_00000000_0_0_0000000000000000_0000000000000000_0000000000000000_1_3f_1
1_c000002c_2_2_0000000000000000_5566778899aabbcc_ddeeff0011223344_1_05_0
